// ==== hw/mem_bus_pkg.sv ====
`default_nettype none

// Types shared by the requester port and the memory bus.
package mem_bus_pkg;

	// Byte address width on both sides of the cache.
	localparam int ADDR_BITS = 32;

	// Data word width on both sides of the cache.
	localparam int WORD_BITS = 32;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [WORD_BITS-1:0] word_t;

endpackage

`default_nettype wire

// ==== hw/l2_cache_pkg.sv ====
`default_nettype none

// Cache geometry and the types used by the cache stages.
package l2_cache_pkg;

	// Kept small so the clearing sweep after reset stays short.
	localparam int INDEX_BITS = 6;
	localparam int TAG_BITS = mem_bus_pkg::ADDR_BITS - INDEX_BITS - 2;

	// A line is {valid, tag, data}, with data in the low bits.
	localparam int LINE_BITS = 1 + TAG_BITS + mem_bus_pkg::WORD_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [31:0] cnt_t;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_BYPASS
	} op_kind_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_COMPARE,
		ST_BUS_READ,
		ST_BUS_WRITE,
		ST_BUS_BYPASS
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/l2_cache_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decoded request from the capture stage to the execute stage.
interface cache_req_if;
	import l2_cache_pkg::*;
	import mem_bus_pkg::*;

	logic valid;
	op_kind_t kind;
	// Original direction, needed when the request bypasses the store.
	logic rw;
	index_t index;
	tag_t tag;
	addr_t addr;
	word_t wdata;
	logic busy;

	modport decode (output valid, kind, rw, index, tag, addr, wdata, input busy);
	modport ctrl (input valid, kind, rw, index, tag, addr, wdata, output busy);
endinterface

// Finished request from the execute stage to the result stage.
interface cache_res_if;
	import mem_bus_pkg::*;

	logic done;
	word_t rdata;
	logic hit;
	logic miss;

	modport ctrl (output done, rdata, hit, miss);
	modport result (input done, rdata, hit, miss);
endinterface

`default_nettype wire

// ==== hw/cache_line_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_line_ram #(
	parameter int DEPTH = 64,
	parameter int WIDTH = 57
) (
	input wire i_clock,
	input wire i_rst,
	input wire i_we,
	input wire [$clog2(DEPTH)-1:0] i_addr,
	input wire [WIDTH-1:0] i_wdata,
	output logic [WIDTH-1:0] o_rdata,
	output logic o_initialized
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] clear_addr;

	// The sweep walks every entry once after reset, one per cycle.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			clear_addr <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			clear_addr <= clear_addr + 1'b1;
			if (clear_addr == $clog2(DEPTH)'(DEPTH - 1)) begin
				o_initialized <= 1'b1;
			end
		end
	end

	// Clearing takes priority over normal writes.
	always_ff @(posedge i_clock) begin
		if (!o_initialized) begin
			mem[clear_addr] <= '0;
		end else if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
		o_rdata <= mem[i_addr];
	end

endmodule

`default_nettype wire

// ==== hw/l2_request_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_request_decode (
	input wire i_clock,
	input wire i_rst,
	input wire i_request,
	input wire i_rw,
	input mem_bus_pkg::addr_t i_address,
	input mem_bus_pkg::word_t i_wdata,
	input wire i_initialized,
	input wire i_ready_out,
	cache_req_if.decode req
);
	import l2_cache_pkg::*;

	logic capture;

	// A finished request keeps i_request high until o_ready has pulsed,
	// so nothing is taken while o_ready is high or the execute stage is busy.
	assign capture = !req.valid && !req.busy && i_request && !i_ready_out;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= capture;
		end
	end

	// The fields stay put until the next capture.
	always_ff @(posedge i_clock) begin
		if (capture) begin
			req.addr <= i_address;
			req.wdata <= i_wdata;
			req.rw <= i_rw;
			req.index <= i_address[INDEX_BITS+1:2];
			req.tag <= i_address[INDEX_BITS+2 +: TAG_BITS];
			if (!i_initialized) begin
				req.kind <= OP_BYPASS;
			end else if (i_rw) begin
				req.kind <= OP_WRITE;
			end else begin
				req.kind <= OP_READ;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/l2_cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_cache_ctrl (
	input wire i_clock,
	input wire i_rst,
	cache_req_if.ctrl req,
	cache_res_if.ctrl res,
	output logic o_ram_we,
	output l2_cache_pkg::index_t o_ram_addr,
	output l2_cache_pkg::line_t o_ram_wdata,
	input l2_cache_pkg::line_t i_ram_rdata,
	output logic o_bus_request,
	output logic o_bus_rw,
	output mem_bus_pkg::addr_t o_bus_address,
	output mem_bus_pkg::word_t o_bus_wdata,
	input wire i_bus_ready,
	input mem_bus_pkg::word_t i_bus_rdata
);
	import l2_cache_pkg::*;
	import mem_bus_pkg::*;

	ctrl_state_t state;
	logic line_valid;
	tag_t line_tag;
	word_t line_data;

	// The index is stable for the whole request, so the store address follows it.
	assign o_ram_addr = req.index;

	assign line_valid = i_ram_rdata[LINE_BITS-1];
	assign line_tag = i_ram_rdata[WORD_BITS +: TAG_BITS];
	assign line_data = i_ram_rdata[WORD_BITS-1:0];

	// Busy also covers the done cycle, while o_ready has not risen yet.
	assign req.busy = (state != ST_IDLE) || res.done;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			o_ram_we <= 1'b0;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
			res.done <= 1'b0;
			res.hit <= 1'b0;
			res.miss <= 1'b0;
		end else begin
			o_ram_we <= 1'b0;
			res.done <= 1'b0;
			res.hit <= 1'b0;
			res.miss <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (req.valid) begin
						case (req.kind)
							OP_READ: begin
								state <= ST_LOOKUP;
							end
							OP_WRITE: begin
								// Allocate on write and send the word out at once.
								o_ram_we <= 1'b1;
								o_ram_wdata <= {1'b1, req.tag, req.wdata};
								o_bus_request <= 1'b1;
								o_bus_rw <= 1'b1;
								o_bus_address <= req.addr;
								o_bus_wdata <= req.wdata;
								state <= ST_BUS_WRITE;
							end
							default: begin
								o_bus_request <= 1'b1;
								o_bus_rw <= req.rw;
								o_bus_address <= req.addr;
								o_bus_wdata <= req.wdata;
								state <= ST_BUS_BYPASS;
							end
						endcase
					end
				end

				// The store registers the line at the end of this cycle.
				ST_LOOKUP: begin
					state <= ST_COMPARE;
				end

				ST_COMPARE: begin
					if (line_valid && line_tag == req.tag) begin
						res.rdata <= line_data;
						res.done <= 1'b1;
						res.hit <= 1'b1;
						state <= ST_IDLE;
					end else begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b0;
						o_bus_address <= req.addr;
						state <= ST_BUS_READ;
					end
				end

				ST_BUS_READ: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_ram_we <= 1'b1;
						o_ram_wdata <= {1'b1, req.tag, i_bus_rdata};
						res.rdata <= i_bus_rdata;
						res.done <= 1'b1;
						res.miss <= 1'b1;
						state <= ST_IDLE;
					end
				end

				ST_BUS_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw <= 1'b0;
						res.done <= 1'b1;
						state <= ST_IDLE;
					end
				end

				ST_BUS_BYPASS: begin
					if (i_bus_ready) begin
						// rdata is left alone on writes so the last read stays visible.
						if (!req.rw) begin
							res.rdata <= i_bus_rdata;
						end
						o_bus_request <= 1'b0;
						o_bus_rw <= 1'b0;
						res.done <= 1'b1;
						state <= ST_IDLE;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/l2_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_result (
	input wire i_clock,
	input wire i_rst,
	cache_res_if.result res,
	output logic o_ready,
	output mem_bus_pkg::word_t o_rdata,
	output l2_cache_pkg::cnt_t o_hit_count,
	output l2_cache_pkg::cnt_t o_miss_count
);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			o_ready <= res.done;
			if (res.hit) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (res.miss) begin
				o_miss_count <= o_miss_count + 1'b1;
			end
		end
	end

	// The execute stage only changes rdata on reads, so this holds across writes.
	always_ff @(posedge i_clock) begin
		if (res.done) begin
			o_rdata <= res.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/l2_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_cache (
	input wire i_clock,
	input wire i_rst,

	input wire i_request,
	input wire i_rw,
	input mem_bus_pkg::addr_t i_address,
	input mem_bus_pkg::word_t i_wdata,
	output logic o_ready,
	output mem_bus_pkg::word_t o_rdata,

	output logic o_bus_request,
	output logic o_bus_rw,
	output mem_bus_pkg::addr_t o_bus_address,
	output mem_bus_pkg::word_t o_bus_wdata,
	input wire i_bus_ready,
	input mem_bus_pkg::word_t i_bus_rdata,

	output l2_cache_pkg::cnt_t o_hit_count,
	output l2_cache_pkg::cnt_t o_miss_count
);
	import l2_cache_pkg::*;

	logic ram_we;
	logic ram_initialized;
	index_t ram_addr;
	line_t ram_wdata;
	line_t ram_rdata;

	cache_req_if req_if ();
	cache_res_if res_if ();

	cache_line_ram #(
		.DEPTH(1 << INDEX_BITS),
		.WIDTH(LINE_BITS)
	) line_ram0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_we(ram_we),
		.i_addr(ram_addr),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata),
		.o_initialized(ram_initialized)
	);

	l2_request_decode decode0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_initialized(ram_initialized),
		.i_ready_out(o_ready),
		.req(req_if.decode)
	);

	l2_cache_ctrl ctrl0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.req(req_if.ctrl),
		.res(res_if.ctrl),
		.o_ram_we(ram_we),
		.o_ram_addr(ram_addr),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	l2_result result0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.res(res_if.result),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// Free-running clock for the testbench, starting low.
module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2) o_clock = ~o_clock;
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_l2_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_l2_cache;
	import mem_bus_pkg::*;
	import l2_cache_pkg::*;

	localparam int CYCLE_LIMIT = 4000;
	localparam int READY_LIMIT = 200;
	localparam int RESET_CYCLES = 3;
	localparam int SWEEP_CYCLES = 64;

	wire clock;
	logic rst;
	logic request;
	logic req_rw;
	addr_t address;
	word_t wdata;
	logic ready;
	word_t rdata_out;
	logic bus_request;
	logic bus_rw;
	addr_t bus_address;
	word_t bus_wdata;
	logic bus_ready = 1'b0;
	word_t bus_rdata = '0;
	cnt_t hit_count;
	cnt_t miss_count;

	int cycle_count = 0;
	logic [31:0] lfsr_state;
	string test_name;
	int errors;
	int pass_count;
	int fail_count;
	int ready_cycle;
	int forced_latency;
	int next_latency;
	cnt_t exp_hits;
	cnt_t exp_misses;

	// Responder state is written only by the responder process.
	word_t bus_mem [logic [29:0]];
	int bus_count = 0;
	logic last_rw = 1'b0;
	addr_t last_addr = '0;
	word_t last_wdata = '0;
	logic resp_active = 1'b0;
	int wait_left = 0;
	int last_wait = 0;
	int bus_done_cycle = 0;
	int bus_unstable = 0;
	int ready_early = 0;

	tb_clock_gen #(.PERIOD_NS(40)) clock_gen0 (.o_clock(clock));

	l2_cache dut0 (
		.i_clock(clock),
		.i_rst(rst),
		.i_request(request),
		.i_rw(req_rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_ready(ready),
		.o_rdata(rdata_out),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_hit_count(hit_count),
		.o_miss_count(miss_count)
	);

	// Unwritten memory words come from a hash that mixes every address bit.
	function automatic word_t default_word(input addr_t addr);
		word_t h;
		h = addr * 32'h9e37_79b1;
		h = h ^ {h[15:0], h[31:16]} ^ addr;
		return h;
	endfunction

	function automatic word_t bus_word(input addr_t addr);
		if (bus_mem.exists(addr[31:2])) begin
			return bus_mem[addr[31:2]];
		end
		return default_word({addr[31:2], 2'b00});
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1 that is stepped once per bit.
	function automatic logic [31:0] lfsr_draw(input int nbits);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// Spreads the sixteen word addresses of the random mix over four tags and
	// the indexes 0x30 to 0x33.
	function automatic addr_t mix_addr(input logic [3:0] k);
		return 32'h0004_00c0 | {18'd0, k[3:2], 12'd0} | {28'd0, k[1:0], 2'd0};
	endfunction

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// Memory bus responder. The latency for each transaction is chosen by the requester side.
	always @(negedge clock) begin
		if (bus_ready) begin
			bus_ready = 1'b0;
			resp_active = 1'b0;
		end else if (bus_request) begin
			if (!resp_active) begin
				resp_active = 1'b1;
				last_rw = bus_rw;
				last_addr = bus_address;
				last_wdata = bus_wdata;
				wait_left = next_latency;
				last_wait = 0;
			end else if (bus_rw !== last_rw || bus_address !== last_addr ||
					bus_wdata !== last_wdata) begin
				bus_unstable++;
			end
			if (ready) begin
				ready_early++;
			end
			if (wait_left == 0) begin
				bus_count++;
				if (last_rw) begin
					bus_mem[last_addr[31:2]] = last_wdata;
				end else begin
					bus_rdata = bus_word(last_addr);
				end
				bus_ready = 1'b1;
				bus_done_cycle = cycle_count;
			end else begin
				wait_left--;
				last_wait++;
			end
		end else if (resp_active) begin
			// The request dropped before the bus answered.
			bus_unstable++;
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("mismatch %s: %s expected %h actual %h", test_name, what, exp, act);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("error %s: %s", test_name, msg);
		errors++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors = 0;
	endtask

	task automatic end_test();
		if (errors == 0) begin
			pass_count++;
			$display("PASS %s", test_name);
		end else begin
			fail_count++;
			$display("FAIL %s with %0d errors", test_name, errors);
		end
	endtask

	// Issues one request and waits for o_ready. Edges are counted after the sampling edge.
	task automatic do_request(input logic rw, input addr_t addr, input word_t data,
			output word_t rdata, output int edges);
		logic [31:0] draw;
		int waited;
		@(negedge clock);
		if (forced_latency >= 0) begin
			next_latency = forced_latency;
		end else begin
			draw = lfsr_draw(2);
			next_latency = int'(draw[1:0]);
		end
		request = 1'b1;
		req_rw = rw;
		address = addr;
		wdata = data;
		rdata = '0;
		edges = -1;
		waited = 0;
		while (!ready && waited < READY_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (ready) begin
			rdata = rdata_out;
			edges = waited - 1;
			ready_cycle = cycle_count;
		end else begin
			report_error("o_ready never rose for the request");
		end
		request = 1'b0;
	endtask

	task automatic check_bus(input int exp_count, input logic exp_rw, input addr_t exp_addr,
			input word_t exp_wdata);
		if (bus_count != exp_count) begin
			report_mismatch("bus transaction count", exp_count, bus_count);
		end
		if (last_rw !== exp_rw) begin
			report_mismatch("bus rw", 32'(exp_rw), 32'(last_rw));
		end
		if (last_addr !== exp_addr) begin
			report_mismatch("bus address", exp_addr, last_addr);
		end
		if (exp_rw && last_wdata !== exp_wdata) begin
			report_mismatch("bus write data", exp_wdata, last_wdata);
		end
	endtask

	// The expected counts run over the whole simulation, starting from zero at reset.
	task automatic check_counts();
		if (hit_count !== exp_hits) begin
			report_mismatch("hit count", exp_hits, hit_count);
		end
		if (miss_count !== exp_misses) begin
			report_mismatch("miss count", exp_misses, miss_count);
		end
	endtask

	task automatic test_bypass();
		word_t rdata;
		word_t exp;
		int edges;
		int n;
		begin_test("bypass_during_clear");
		n = bus_count;
		exp = bus_word(32'h0000_0104);
		do_request(1'b0, 32'h0000_0104, '0, rdata, edges);
		check_bus(n + 1, 1'b0, 32'h0000_0104, '0);
		if (rdata !== exp) begin
			report_mismatch("read data", exp, rdata);
		end
		do_request(1'b1, 32'h0000_0208, 32'h1357_9bdf, rdata, edges);
		check_bus(n + 2, 1'b1, 32'h0000_0208, 32'h1357_9bdf);
		do_request(1'b0, 32'h0000_0208, '0, rdata, edges);
		check_bus(n + 3, 1'b0, 32'h0000_0208, '0);
		if (rdata !== 32'h1357_9bdf) begin
			report_mismatch("read after bypass write", 32'h1357_9bdf, rdata);
		end
		if (ready_cycle >= RESET_CYCLES + SWEEP_CYCLES) begin
			report_error("the requests outlasted the clearing sweep");
		end
		check_counts();
		end_test();
	endtask

	task automatic test_miss_then_hit();
		word_t rdata;
		word_t exp;
		int edges;
		int n;
		begin_test("read_miss_then_hit");
		n = bus_count;
		exp = bus_word(32'h0000_1040);
		do_request(1'b0, 32'h0000_1040, '0, rdata, edges);
		check_bus(n + 1, 1'b0, 32'h0000_1040, '0);
		if (rdata !== exp) begin
			report_mismatch("miss data", exp, rdata);
		end
		exp_misses++;
		check_counts();
		do_request(1'b0, 32'h0000_1040, '0, rdata, edges);
		if (bus_count != n + 1) begin
			report_mismatch("bus transactions on hit", n + 1, bus_count);
		end
		if (rdata !== exp) begin
			report_mismatch("hit data", exp, rdata);
		end
		exp_hits++;
		check_counts();
		if (edges != 4) begin
			report_mismatch("hit latency", 4, edges);
		end
		end_test();
	endtask

	task automatic test_write_allocate();
		word_t rdata;
		int edges;
		int n;
		begin_test("write_through_allocate");
		n = bus_count;
		do_request(1'b1, 32'h0000_3150, 32'hc0de_1234, rdata, edges);
		check_bus(n + 1, 1'b1, 32'h0000_3150, 32'hc0de_1234);
		if (bus_word(32'h0000_3150) !== 32'hc0de_1234) begin
			report_mismatch("bus memory", 32'hc0de_1234, bus_word(32'h0000_3150));
		end
		check_counts();
		do_request(1'b0, 32'h0000_3150, '0, rdata, edges);
		if (bus_count != n + 1) begin
			report_mismatch("bus transactions on read", n + 1, bus_count);
		end
		if (rdata !== 32'hc0de_1234) begin
			report_mismatch("read data", 32'hc0de_1234, rdata);
		end
		exp_hits++;
		check_counts();
		end_test();
	endtask

	task automatic test_index_conflict();
		addr_t addr;
		word_t rdata;
		word_t exp;
		int edges;
		int n;
		begin_test("index_conflict");
		for (int i = 0; i < 4; i++) begin
			addr = (i % 2 == 0) ? 32'h0000_2080 : 32'h0001_2080;
			exp = bus_word(addr);
			n = bus_count;
			do_request(1'b0, addr, '0, rdata, edges);
			check_bus(n + 1, 1'b0, addr, '0);
			if (rdata !== exp) begin
				report_mismatch("read data", exp, rdata);
			end
			exp_misses++;
		end
		check_counts();
		end_test();
	endtask

	task automatic test_random_mix();
		word_t model [16];
		logic [1:0] shadow_tag [4];
		logic shadow_valid [4];
		logic [31:0] draw;
		logic rw;
		logic [3:0] k;
		logic hit;
		word_t data;
		word_t rdata;
		int edges;
		int n;
		begin_test("random_mix");
		for (int i = 0; i < 16; i++) begin
			model[i] = default_word(mix_addr(4'(i)));
		end
		for (int i = 0; i < 4; i++) begin
			shadow_valid[i] = 1'b0;
			shadow_tag[i] = '0;
		end
		for (int op = 0; op < 60; op++) begin
			draw = lfsr_draw(1);
			rw = draw[0];
			draw = lfsr_draw(4);
			k = draw[3:0];
			data = lfsr_draw(32);
			n = bus_count;
			if (rw) begin
				do_request(1'b1, mix_addr(k), data, rdata, edges);
				check_bus(n + 1, 1'b1, mix_addr(k), data);
				model[k] = data;
			end else begin
				hit = shadow_valid[k[1:0]] && shadow_tag[k[1:0]] == k[3:2];
				do_request(1'b0, mix_addr(k), '0, rdata, edges);
				if (rdata !== model[k]) begin
					report_mismatch("read data", model[k], rdata);
				end
				if (bus_count != n + (hit ? 0 : 1)) begin
					report_mismatch("bus transactions on read", n + (hit ? 0 : 1), bus_count);
				end
				if (hit) begin
					exp_hits++;
				end else begin
					exp_misses++;
				end
			end
			// Both a write and a read miss leave the line holding this tag.
			shadow_valid[k[1:0]] = 1'b1;
			shadow_tag[k[1:0]] = k[3:2];
		end
		check_counts();
		end_test();
	endtask

	task automatic test_backpressure();
		word_t rdata;
		word_t exp;
		int edges;
		int n;
		int unstable;
		int early;
		begin_test("bus_backpressure");
		n = bus_count;
		unstable = bus_unstable;
		early = ready_early;
		exp = bus_word(32'h0000_50e8);
		forced_latency = 3;
		do_request(1'b0, 32'h0000_50e8, '0, rdata, edges);
		forced_latency = -1;
		check_bus(n + 1, 1'b0, 32'h0000_50e8, '0);
		if (last_wait != 3) begin
			report_mismatch("bus wait cycles", 3, last_wait);
		end
		if (bus_unstable != unstable) begin
			report_error("the bus request changed while the bus was not ready");
		end
		if (ready_early != early || ready_cycle <= bus_done_cycle) begin
			report_error("o_ready pulsed before the bus responded");
		end
		if (rdata !== exp) begin
			report_mismatch("read data", exp, rdata);
		end
		exp_misses++;
		check_counts();
		end_test();
	endtask

	initial begin
		rst = 1'b1;
		request = 1'b0;
		req_rw = 1'b0;
		address = '0;
		wdata = '0;
		lfsr_state = 32'ha937;
		forced_latency = -1;
		next_latency = 0;
		ready_cycle = 0;
		pass_count = 0;
		fail_count = 0;
		errors = 0;
		exp_hits = '0;
		exp_misses = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		rst = 1'b0;

		test_bypass();
		// Give the clearing sweep time to finish before the cached tests.
		while (cycle_count < RESET_CYCLES + SWEEP_CYCLES + 8) begin
			@(negedge clock);
		end
		test_miss_then_hit();
		test_write_allocate();
		test_index_conflict();
		test_random_mix();
		test_backpressure();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/mem_bus_pkg.sv
hw/l2_cache_pkg.sv
hw/l2_cache_if.sv
hw/cache_line_ram.sv
hw/l2_request_decode.sv
hw/l2_cache_ctrl.sv
hw/l2_result.sv
hw/l2_cache.sv
verif/tb_clock_gen.sv
verif/tb_l2_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0
TOP ?= tb_l2_cache
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator's exit status is hidden by tee, so the log decides.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
